// ==== hw/axi_pkg.sv ====
package axi_pkg;

    // Byte address width of the AXI subordinate port.
    localparam int addr_width = 12;

    // Data bus width in bits.
    localparam int data_width = 32;

    // One strobe bit per byte lane.
    localparam int strb_width = data_width / 8;

    // Two-bit response code carried on R and B.
    typedef logic [1:0] axi_resp_t;

    // Normal access completed.
    localparam axi_resp_t resp_okay = 2'd0;

    // Subordinate error, used for addresses beyond the bank.
    localparam axi_resp_t resp_slverr = 2'd2;

endpackage

// ==== hw/mem_pkg.sv ====
package mem_pkg;

    // Number of 32-bit words held in the SRAM bank.
    localparam int mem_depth = 256;

    // Word address width needed to index the bank.
    localparam int mem_addr_width = $clog2(mem_depth);

    // Requesters sharing the single SRAM port.
    localparam int num_ports = 2;

    // Arbiter index of the read channel unit.
    localparam int port_read = 0;

    // Arbiter index of the write channel unit.
    localparam int port_write = 1;

endpackage

// ==== hw/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;

    import axi_pkg::*;
    import mem_pkg::*;

    // Request side, owned by the channel unit.
    logic                      req;
    logic                      we;
    logic [mem_addr_width-1:0] addr;
    logic [data_width-1:0]     wdata;
    logic [strb_width-1:0]     strb;

    // Response side, owned by the arbiter.
    logic                      gnt;
    logic                      rvalid;
    logic [data_width-1:0]     rdata;

    // Channel unit view.
    modport requester (
        output req, we, addr, wdata, strb,
        input  gnt, rvalid, rdata
    );

    // Arbiter view.
    modport arbiter (
        input  req, we, addr, wdata, strb,
        output gnt, rvalid, rdata
    );

endinterface

// ==== hw/axi_read_unit.sv ====
`timescale 1ns/1ps

module axi_read_unit (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [axi_pkg::addr_width-1:0]  araddr_i,
    input  logic                            arvalid_i,
    output logic                            arready_o,
    output logic [axi_pkg::data_width-1:0]  rdata_o,
    output axi_pkg::axi_resp_t              rresp_o,
    output logic                            rvalid_o,
    input  logic                            rready_i,
    mem_port_if.requester                   mem
);

    import axi_pkg::*;
    import mem_pkg::*;

    // Idle is neither flag set; wait and resp are never set together.
    logic                      wait_q;
    logic                      resp_q;
    logic                      req_q;
    logic [mem_addr_width-1:0] addr_q;
    logic [data_width-1:0]     rdata_q;
    axi_resp_t                 rresp_q;
    logic                      ar_hs;
    logic                      ar_err;

    // New addresses only while idle.
    assign arready_o = !wait_q && !resp_q;
    assign ar_hs     = arvalid_i && arready_o;

    // Word index past the bank means SLVERR.
    assign ar_err = araddr_i[addr_width-1:2] >= mem_depth;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wait_q <= 1'b0;
            resp_q <= 1'b0;
            req_q  <= 1'b0;
        end else begin
            if (ar_hs) begin
                // Out-of-range reads go straight to the response.
                if (ar_err) begin
                    resp_q <= 1'b1;
                end else begin
                    wait_q <= 1'b1;
                    req_q  <= 1'b1;
                end
            end
            // Request drops once the arbiter takes it.
            if (req_q && mem.gnt) begin
                req_q <= 1'b0;
            end
            if (wait_q && mem.rvalid) begin
                wait_q <= 1'b0;
                resp_q <= 1'b1;
            end
            if (resp_q && rready_i) begin
                resp_q <= 1'b0;
            end
        end
    end

    // Address, response and data registers.
    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            addr_q  <= araddr_i[mem_addr_width+1:2];
            rresp_q <= ar_err ? resp_slverr : resp_okay;
            rdata_q <= '0;
        end
        if (wait_q && mem.rvalid) begin
            rdata_q <= mem.rdata;
        end
    end

    // Read-only requester.
    assign mem.req   = req_q;
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
    assign mem.strb  = '0;

    assign rvalid_o = resp_q;
    assign rdata_o  = rdata_q;
    assign rresp_o  = rresp_q;

endmodule

// ==== hw/axi_write_unit.sv ====
`timescale 1ns/1ps

module axi_write_unit (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [axi_pkg::addr_width-1:0]  awaddr_i,
    input  logic                            awvalid_i,
    input  logic [axi_pkg::data_width-1:0]  wdata_i,
    input  logic [axi_pkg::strb_width-1:0]  wstrb_i,
    input  logic                            wvalid_i,
    output logic                            awready_o,
    output logic                            wready_o,
    output axi_pkg::axi_resp_t              bresp_o,
    output logic                            bvalid_o,
    input  logic                            bready_i,
    mem_port_if.requester                   mem
);

    import axi_pkg::*;
    import mem_pkg::*;

    logic                      aw_full_q;
    logic                      w_full_q;
    logic                      bvalid_q;
    logic [mem_addr_width-1:0] addr_q;
    logic                      aw_err_q;
    logic [data_width-1:0]     wdata_q;
    logic [strb_width-1:0]     wstrb_q;
    axi_resp_t                 bresp_q;
    logic                      aw_hs;
    logic                      w_hs;
    logic                      both;
    logic                      issue;

    // Each channel has its own holding register.
    assign awready_o = !aw_full_q;
    assign wready_o  = !w_full_q;
    assign aw_hs     = awvalid_i && awready_o;
    assign w_hs      = wvalid_i && wready_o;

    // Both halves held and no response outstanding.
    assign both = aw_full_q && w_full_q && !bvalid_q;

    // Errors complete without the memory.
    assign issue = both && (aw_err_q || mem.gnt);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            aw_full_q <= 1'b0;
            w_full_q  <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_full_q <= 1'b1;
            end
            if (w_hs) begin
                w_full_q <= 1'b1;
            end
            if (issue) begin
                bvalid_q <= 1'b1;
            end
            // Registers free up only after B leaves.
            if (bvalid_q && bready_i) begin
                bvalid_q  <= 1'b0;
                aw_full_q <= 1'b0;
                w_full_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            addr_q   <= awaddr_i[mem_addr_width+1:2];
            aw_err_q <= awaddr_i[addr_width-1:2] >= mem_depth;
        end
        if (w_hs) begin
            wdata_q <= wdata_i;
            wstrb_q <= wstrb_i;
        end
        if (issue) begin
            bresp_q <= aw_err_q ? resp_slverr : resp_okay;
        end
    end

    // Strobed write request.
    assign mem.req   = both && !aw_err_q;
    assign mem.we    = 1'b1;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;
    assign mem.strb  = wstrb_q;

    assign bvalid_o = bvalid_q;
    assign bresp_o  = bresp_q;

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                                clk_i,
    input  logic                                rst_i,
    mem_port_if.arbiter                         rd_port,
    mem_port_if.arbiter                         wr_port,
    output logic                                mem_req_o,
    output logic                                mem_we_o,
    output logic [mem_pkg::mem_addr_width-1:0]  mem_addr_o,
    output logic [axi_pkg::data_width-1:0]      mem_wdata_o,
    output logic [axi_pkg::strb_width-1:0]      mem_strb_o,
    input  logic [axi_pkg::data_width-1:0]      mem_rdata_i
);

    import mem_pkg::*;

    logic [num_ports-1:0] req_vec;
    logic [num_ports-1:0] gnt_vec;
    logic [num_ports-1:0] rvalid_q;
    logic                 last_wr_q;
    logic                 sel_wr;

    assign req_vec[port_read]  = rd_port.req;
    assign req_vec[port_write] = wr_port.req;

    // Read wins unless the write port was passed over last time.
    always_comb begin
        gnt_vec = '0;
        if (req_vec[port_read] && (!req_vec[port_write] || last_wr_q)) begin
            gnt_vec[port_read] = 1'b1;
        end else if (req_vec[port_write]) begin
            gnt_vec[port_write] = 1'b1;
        end
    end

    // Pointer starts as if write went last, so read is favored.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_wr_q <= 1'b1;
            rvalid_q  <= '0;
        end else begin
            if (|gnt_vec) begin
                last_wr_q <= gnt_vec[port_write];
            end
            // Read data returns one cycle after a granted read.
            rvalid_q[port_read]  <= gnt_vec[port_read] && !rd_port.we;
            rvalid_q[port_write] <= gnt_vec[port_write] && !wr_port.we;
        end
    end

    assign sel_wr = gnt_vec[port_write];

    // Granted port drives the bank.
    assign mem_req_o   = |gnt_vec;
    assign mem_we_o    = sel_wr ? wr_port.we    : rd_port.we;
    assign mem_addr_o  = sel_wr ? wr_port.addr  : rd_port.addr;
    assign mem_wdata_o = sel_wr ? wr_port.wdata : rd_port.wdata;
    assign mem_strb_o  = sel_wr ? wr_port.strb  : rd_port.strb;

    assign rd_port.gnt    = gnt_vec[port_read];
    assign rd_port.rvalid = rvalid_q[port_read];
    assign rd_port.rdata  = mem_rdata_i;
    assign wr_port.gnt    = gnt_vec[port_write];
    assign wr_port.rvalid = rvalid_q[port_write];
    assign wr_port.rdata  = mem_rdata_i;

endmodule

// ==== hw/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank (
    input  logic                                clk_i,
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic [mem_pkg::mem_addr_width-1:0]  addr_i,
    input  logic [axi_pkg::data_width-1:0]      wdata_i,
    input  logic [axi_pkg::strb_width-1:0]      strb_i,
    output logic [axi_pkg::data_width-1:0]      rdata_o
);

    import axi_pkg::*;
    import mem_pkg::*;

    // Storage array of mem_depth words.
    logic [data_width-1:0] mem_q [mem_depth];
    logic [data_width-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                // Only enabled byte lanes are written.
                for (int b = 0; b < strb_width; b++) begin
                    if (strb_i[b]) begin
                        mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[addr_i];
            end
        end
    end

    // One cycle of read latency.
    assign rdata_o = rdata_q;

endmodule

// ==== hw/axi_mem_top.sv ====
`timescale 1ns/1ps

module axi_mem_top (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [axi_pkg::addr_width-1:0]  s_awaddr_i,
    input  logic                            s_awvalid_i,
    output logic                            s_awready_o,
    input  logic [axi_pkg::data_width-1:0]  s_wdata_i,
    input  logic [axi_pkg::strb_width-1:0]  s_wstrb_i,
    input  logic                            s_wvalid_i,
    output logic                            s_wready_o,
    output axi_pkg::axi_resp_t              s_bresp_o,
    output logic                            s_bvalid_o,
    input  logic                            s_bready_i,
    input  logic [axi_pkg::addr_width-1:0]  s_araddr_i,
    input  logic                            s_arvalid_i,
    output logic                            s_arready_o,
    output logic [axi_pkg::data_width-1:0]  s_rdata_o,
    output axi_pkg::axi_resp_t              s_rresp_o,
    output logic                            s_rvalid_o,
    input  logic                            s_rready_i
);

    import axi_pkg::*;
    import mem_pkg::*;

    // One request port per channel unit.
    mem_port_if rd_port_if ();
    mem_port_if wr_port_if ();

    // Bank-side wires after arbitration.
    logic                      mem_req;
    logic                      mem_we;
    logic [mem_addr_width-1:0] mem_addr;
    logic [data_width-1:0]     mem_wdata;
    logic [strb_width-1:0]     mem_strb;
    logic [data_width-1:0]     mem_rdata;

    axi_read_unit read_unit_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .araddr_i  (s_araddr_i),
        .arvalid_i (s_arvalid_i),
        .arready_o (s_arready_o),
        .rdata_o   (s_rdata_o),
        .rresp_o   (s_rresp_o),
        .rvalid_o  (s_rvalid_o),
        .rready_i  (s_rready_i),
        .mem       (rd_port_if.requester)
    );

    axi_write_unit write_unit_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .awaddr_i  (s_awaddr_i),
        .awvalid_i (s_awvalid_i),
        .wdata_i   (s_wdata_i),
        .wstrb_i   (s_wstrb_i),
        .wvalid_i  (s_wvalid_i),
        .awready_o (s_awready_o),
        .wready_o  (s_wready_o),
        .bresp_o   (s_bresp_o),
        .bvalid_o  (s_bvalid_o),
        .bready_i  (s_bready_i),
        .mem       (wr_port_if.requester)
    );

    // Single SRAM port shared round-robin.
    mem_arbiter arbiter_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rd_port     (rd_port_if.arbiter),
        .wr_port     (wr_port_if.arbiter),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_strb_o  (mem_strb),
        .mem_rdata_i (mem_rdata)
    );

    sram_bank bank_i (
        .clk_i   (clk_i),
        .req_i   (mem_req),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .strb_i  (mem_strb),
        .rdata_o (mem_rdata)
    );

endmodule

// ==== test/axi_mem_assert.sv ====
`timescale 1ns/1ps

module axi_mem_assert (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            arvalid_i,
    input  logic                            arready_i,
    input  logic                            rvalid_i,
    input  logic                            rready_i,
    input  logic [axi_pkg::data_width-1:0]  rdata_i,
    input  axi_pkg::axi_resp_t              rresp_i,
    input  logic                            bvalid_i,
    input  logic                            bready_i,
    input  axi_pkg::axi_resp_t              bresp_i
);

    // Reads accepted but not yet answered.
    int ar_open;
    // Count of failed assertions.
    int fail_count = 0;

    always @(posedge clk_i) begin
        if (rst_i) begin
            ar_open <= 0;
        end else begin
            ar_open <= ar_open + ((arvalid_i && arready_i) ? 1 : 0)
                               - ((rvalid_i && rready_i) ? 1 : 0);
        end
    end

    // R payload holds while stalled.
    r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
        else begin
            $error("R channel changed while rready was low");
            fail_count++;
        end

    // B payload holds while stalled.
    b_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
        else begin
            $error("B channel changed while bready was low");
            fail_count++;
        end

    // Nothing valid right after reset.
    idle_after_reset: assert property (@(posedge clk_i)
        $fell(rst_i) |-> !rvalid_i && !bvalid_i)
        else begin
            $error("Response valid in the first cycle after reset");
            fail_count++;
        end

    // Every R needs an AR before it.
    r_after_ar: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_i |-> ar_open > 0)
        else begin
            $error("Read response without an accepted AR");
            fail_count++;
        end

endmodule

// ==== test/axi_mem_checker.sv ====
`timescale 1ns/1ps

module axi_mem_checker (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [axi_pkg::addr_width-1:0]  awaddr_i,
    input  logic                            awvalid_i,
    input  logic                            awready_i,
    input  logic [axi_pkg::data_width-1:0]  wdata_i,
    input  logic [axi_pkg::strb_width-1:0]  wstrb_i,
    input  logic                            wvalid_i,
    input  logic                            wready_i,
    input  axi_pkg::axi_resp_t              bresp_i,
    input  logic                            bvalid_i,
    input  logic                            bready_i,
    input  logic [axi_pkg::addr_width-1:0]  araddr_i,
    input  logic                            arvalid_i,
    input  logic                            arready_i,
    input  logic [axi_pkg::data_width-1:0]  rdata_i,
    input  axi_pkg::axi_resp_t              rresp_i,
    input  logic                            rvalid_i,
    input  logic                            rready_i
);

    import axi_pkg::*;
    import mem_pkg::*;

    // Model of the bank contents.
    logic [data_width-1:0] model_mem [mem_depth];
    // Expected responses in channel order.
    logic [data_width-1:0] exp_rdata_q [$];
    axi_resp_t             exp_rresp_q [$];
    axi_resp_t             exp_bresp_q [$];
    // Write halves waiting for their partner.
    logic [addr_width-1:0] aw_q [$];
    logic [data_width-1:0] wd_q [$];
    logic [strb_width-1:0] ws_q [$];
    logic                  rst_q;
    int                    err_count = 0;
    int                    check_count = 0;

    initial begin
        for (int i = 0; i < mem_depth; i++) begin
            model_mem[i] = '0;
        end
    end

    // Expected result of one access; a write also updates the model.
    function automatic void ref_access(input logic wr, input logic [addr_width-1:0] addr,
                                       input logic [data_width-1:0] wdata,
                                       input logic [strb_width-1:0] strb,
                                       output logic [data_width-1:0] data,
                                       output axi_resp_t resp);
        int unsigned word;
        word = 32'(addr) >> 2;
        data = '0;
        resp = resp_okay;
        if (word >= mem_depth) begin
            // Beyond the bank the access errors and the memory stays untouched.
            resp = resp_slverr;
        end else if (wr) begin
            for (int b = 0; b < strb_width; b++) begin
                if (strb[b]) begin
                    model_mem[word][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else begin
            data = model_mem[word];
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch %s: expected %h, got %h", name, exp, got);
        end
    endtask

    always @(posedge clk_i) begin
        logic [data_width-1:0] exp_data;
        axi_resp_t             exp_resp;
        rst_q <= rst_i;
        // First edge after reset release.
        if (rst_q && !rst_i) begin
            check_value("arready", 32'(1'b1), 32'(arready_i));
            check_value("awready", 32'(1'b1), 32'(awready_i));
            check_value("wready", 32'(1'b1), 32'(wready_i));
            check_value("rvalid", 32'(1'b0), 32'(rvalid_i));
            check_value("bvalid", 32'(1'b0), 32'(bvalid_i));
        end
        if (!rst_i) begin
            if (arvalid_i && arready_i) begin
                ref_access(1'b0, araddr_i, '0, '0, exp_data, exp_resp);
                exp_rdata_q.push_back(exp_data);
                exp_rresp_q.push_back(exp_resp);
            end
            if (awvalid_i && awready_i) begin
                aw_q.push_back(awaddr_i);
            end
            if (wvalid_i && wready_i) begin
                wd_q.push_back(wdata_i);
                ws_q.push_back(wstrb_i);
            end
            // A write counts once both halves are in.
            if (aw_q.size() > 0 && wd_q.size() > 0) begin
                ref_access(1'b1, aw_q.pop_front(), wd_q.pop_front(), ws_q.pop_front(),
                           exp_data, exp_resp);
                exp_bresp_q.push_back(exp_resp);
            end
            if (rvalid_i && rready_i) begin
                if (exp_rdata_q.size() == 0) begin
                    err_count++;
                    $display("R handshake seen with no read outstanding");
                end else begin
                    check_value("rdata", exp_rdata_q.pop_front(), rdata_i);
                    check_value("rresp", 32'(exp_rresp_q.pop_front()), 32'(rresp_i));
                end
            end
            if (bvalid_i && bready_i) begin
                if (exp_bresp_q.size() == 0) begin
                    err_count++;
                    $display("B handshake seen with no write outstanding");
                end else begin
                    check_value("bresp", 32'(exp_bresp_q.pop_front()), 32'(bresp_i));
                end
            end
        end
    end

endmodule

// ==== test/tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem;

    import axi_pkg::*;
    import mem_pkg::*;

    localparam int half_words  = mem_depth / 2;
    localparam int partial_cnt = 32;
    localparam int oor_cnt     = 4;
    localparam int rand_cnt    = 100;
    localparam int clk_period  = 40;
    // Every read and every write counted once.
    localparam int num_txns = 2 * half_words + 2 * partial_cnt + 3 * oor_cnt + 4
                              + 2 * rand_cnt;

    logic                  clk;
    logic                  rst;
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    axi_resp_t             bresp;
    logic                  bvalid;
    logic                  bready;
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [data_width-1:0] rdata;
    axi_resp_t             rresp;
    logic                  rvalid;
    logic                  rready;
    int                    test_count = 0;
    int                    err_before;
    int                    errors;

    always #(clk_period / 2) clk = ~clk;

    axi_mem_top dut_i (
        .clk_i (clk), .rst_i (rst),
        .s_awaddr_i (awaddr), .s_awvalid_i (awvalid), .s_awready_o (awready),
        .s_wdata_i (wdata), .s_wstrb_i (wstrb), .s_wvalid_i (wvalid), .s_wready_o (wready),
        .s_bresp_o (bresp), .s_bvalid_o (bvalid), .s_bready_i (bready),
        .s_araddr_i (araddr), .s_arvalid_i (arvalid), .s_arready_o (arready),
        .s_rdata_o (rdata), .s_rresp_o (rresp), .s_rvalid_o (rvalid), .s_rready_i (rready)
    );

    axi_mem_checker checker_i (
        .clk_i (clk), .rst_i (rst),
        .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_i (awready),
        .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_i (wready),
        .bresp_i (bresp), .bvalid_i (bvalid), .bready_i (bready),
        .araddr_i (araddr), .arvalid_i (arvalid), .arready_i (arready),
        .rdata_i (rdata), .rresp_i (rresp), .rvalid_i (rvalid), .rready_i (rready)
    );

    bind axi_mem_top axi_mem_assert assert_i (
        .clk_i (clk_i), .rst_i (rst_i),
        .arvalid_i (s_arvalid_i), .arready_i (s_arready_o),
        .rvalid_i (s_rvalid_o), .rready_i (s_rready_i),
        .rdata_i (s_rdata_o), .rresp_i (s_rresp_o),
        .bvalid_i (s_bvalid_o), .bready_i (s_bready_i), .bresp_i (s_bresp_o)
    );

    function automatic logic [addr_width-1:0] word_addr(input int word);
        return addr_width'(word << 2);
    endfunction

    // Fill value derived from every address bit.
    function automatic logic [data_width-1:0] fill_word(input int word);
        return (32'(word) * 32'h9E37_79B1) ^ 32'hA5A5_0000;
    endfunction

    // All channel tasks start and end on a falling edge.
    task automatic send_ar(input logic [addr_width-1:0] addr);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        // Handshake happens on the rising edge in between.
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic send_aw(input logic [addr_width-1:0] addr);
        awaddr  = addr;
        awvalid = 1'b1;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [data_width-1:0] data, input logic [strb_width-1:0] strb);
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        while (!wready) @(negedge clk);
        @(negedge clk);
        wvalid = 1'b0;
    endtask

    // Random stall of 0 to max_stall cycles before ready.
    task automatic take_r(input int max_stall);
        int stall;
        stall = $urandom_range(max_stall, 0);
        while (!rvalid) @(negedge clk);
        repeat (stall) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic take_b(input int max_stall);
        int stall;
        stall = $urandom_range(max_stall, 0);
        while (!bvalid) @(negedge clk);
        repeat (stall) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_word(input logic [addr_width-1:0] addr, input int max_stall);
        send_ar(addr);
        take_r(max_stall);
    endtask

    // Order 0 sends AW and W together, 1 sends W first, 2 sends AW first.
    task automatic write_word(input logic [addr_width-1:0] addr, input logic [data_width-1:0] data,
                              input logic [strb_width-1:0] strb, input int order,
                              input int max_stall);
        case (order)
            1: begin
                send_w(data, strb);
                send_aw(addr);
            end
            2: begin
                send_aw(addr);
                send_w(data, strb);
            end
            default: begin
                fork
                    send_aw(addr);
                    send_w(data, strb);
                join
            end
        endcase
        take_b(max_stall);
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, checker_i.err_count - err_before);
        err_before = checker_i.err_count;
    endtask

    // Watchdog sized from the transaction count.
    initial begin
        #(num_txns * 50 * clk_period);
        $display("timeout: a response did not arrive within %0d transactions of time", num_txns);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(17));
        clk     = 1'b0;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        err_before = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Checker samples the idle outputs on the first edge.
        repeat (2) @(negedge clk);
        end_test("reset state");

        for (int w = half_words; w < mem_depth; w++) begin
            write_word(word_addr(w), fill_word(w), '1, 0, 0);
        end
        for (int w = half_words; w < mem_depth; w++) begin
            read_word(word_addr(w), 0);
        end
        end_test("full-word write and read");

        repeat (partial_cnt) begin
            int w;
            w = half_words + $urandom_range(half_words - 1);
            write_word(word_addr(w), $urandom, strb_width'($urandom), 0, 0);
            read_word(word_addr(w), 0);
        end
        end_test("partial strobes");

        // Writes alias words half_words up if the range check fails.
        for (int i = 0; i < oor_cnt; i++) begin
            read_word(addr_width'(1024 + $urandom_range(3071)), 0);
            write_word(addr_width'(12'h600 + 4 * i), $urandom, '1, 0, 0);
            read_word(word_addr(half_words + i), 0);
        end
        end_test("out of range");

        write_word(word_addr(half_words + 10), $urandom, '1, 1, 0);
        read_word(word_addr(half_words + 10), 0);
        write_word(word_addr(half_words + 11), $urandom, '1, 2, 0);
        read_word(word_addr(half_words + 11), 0);
        end_test("write channel order");

        // Reads stay in the upper half, writes in the lower half.
        fork
            begin
                repeat (rand_cnt) begin
                    read_word(word_addr(half_words + $urandom_range(half_words - 1)), 3);
                end
            end
            begin
                repeat (rand_cnt) begin
                    write_word(word_addr($urandom_range(half_words - 1)), $urandom,
                               strb_width'($urandom), $urandom_range(2), 3);
                end
            end
        join
        end_test("concurrent traffic");

        errors = checker_i.err_count + dut_i.assert_i.fail_count;
        $display("tests %0d, checks %0d, errors %0d", test_count, checker_i.check_count, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hw/axi_pkg.sv
hw/mem_pkg.sv
hw/mem_port_if.sv
hw/axi_read_unit.sv
hw/axi_write_unit.sv
hw/mem_arbiter.sv
hw/sram_bank.sv
hw/axi_mem_top.sv
test/axi_mem_assert.sv
test/axi_mem_checker.sv
test/tb_axi_mem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the AXI memory testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_axi_mem -f project.f -o sim_axi_mem

output=$(./obj_dir/sim_axi_mem 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
